// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = cpu_tb
FILELIST  = project.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)_sim
	./obj_dir/$(TOP)_sim | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== project.f ====
source/cpu_pkg.sv
source/cpu_decode.sv
source/cpu_sequencer.sv
source/cpu_alu.sv
source/cpu_datapath.sv
source/cpu_top.sv
tests/cpu_props.sv
tests/cpu_tb.sv

// ==== source/cpu_alu.sv ====
module cpu_alu
(
    input  cpu_pkg::byte_t   a,
    input  cpu_pkg::byte_t   b,
    input  logic             carry_in,
    input  cpu_pkg::alu_op_t op,        // ORA,AND,EOR,ADC,-,LDA,-,SBC
    output cpu_pkg::byte_t   result,
    output logic             carry_out,
    output logic             overflow
);

    import cpu_pkg::*;

    logic       subtract;
    byte_t      addend;
    logic [8:0] sum;   // With carry

    assign subtract = op[2];                  // SBC row
    assign addend   = subtract ? ~b : b;      // A + ~B + C for subtraction
    assign sum      = {1'b0, a} + {1'b0, addend} + 9'(carry_in);

    always_comb
    begin
        case (op)
            3'd0:    result = a | b;      // ORA
            3'd1:    result = a & b;      // AND
            3'd2:    result = a ^ b;      // EOR
            3'd3:    result = sum[7:0];   // ADC
            3'd5:    result = b;          // LDA
            3'd7:    result = sum[7:0];   // SBC
            default: result = a;
        endcase
    end

    // Signed overflow when both inputs agree and the result differs
    assign overflow  = (a[7] ^ result[7]) & (addend[7] ^ result[7]);
    assign carry_out = sum[8];

endmodule

// ==== source/cpu_datapath.sv ====
module cpu_datapath
(
    input  logic              clock,
    input  logic              reset,
    input  logic              enable,
    input  cpu_pkg::byte_t    data_in,
    input  cpu_pkg::control_t control,
    input  cpu_pkg::byte_t    opcode,
    input  cpu_pkg::byte_t    alu_result,
    input  logic              alu_carry,
    input  logic              alu_overflow,
    output cpu_pkg::byte_t    alu_a,
    output cpu_pkg::byte_t    data_byte,
    output cpu_pkg::flags_t   flags,
    output logic              branch_cross,
    output cpu_pkg::bus_t     bus,
    output cpu_pkg::debug_t   debug
);

    import cpu_pkg::*;

    addr_t      pc;
    byte_t      a;
    byte_t      x;
    byte_t      y;
    byte_t      address_low;    // Operand low byte for absolute
    logic [9:0] branch_sum;     // Branch sum of the previous cycle
    byte_t      db;             // Internal data bus
    byte_t      inc_x;
    byte_t      inc_y;
    byte_t      dec_x;
    byte_t      dec_y;
    logic [9:0] branch_result;
    byte_t      branch_carry;
    addr_t      next_pc;
    addr_t      address;
    byte_t      store_data;

    assign inc_x = x + 8'd1;
    assign inc_y = y + 8'd1;
    assign dec_x = x - 8'd1;
    assign dec_y = y - 8'd1;

    assign db =
        (control.db_data_in ? data_byte  : '0) |
        (control.db_alu     ? alu_result : '0) |
        (control.db_a       ? a          : '0) |
        (control.db_x       ? x          : '0) |
        (control.db_y       ? y          : '0) |
        (control.db_inc_x   ? inc_x      : '0) |
        (control.db_inc_y   ? inc_y      : '0) |
        (control.db_dec_x   ? dec_x      : '0) |
        (control.db_dec_y   ? dec_y      : '0);

    // PCL plus signed offset, bits 9:8 give the page step
    assign branch_result = {2'b00, pc[7:0]} + {{2{data_byte[7]}}, data_byte};
    assign branch_cross  = branch_result[9:8] != 2'b00;
    assign branch_carry  = {{7{branch_sum[9]}}, branch_sum[8]};  // +1 or -1

    always_comb
    begin
        if (control.pc_branch_low)
            next_pc = {pc[15:8], branch_result[7:0]};
        else if (control.pc_branch_high)
            next_pc = {pc[15:8] + branch_carry, pc[7:0]};
        else if (control.pc_vector)
            next_pc = {data_in, data_byte};  // High byte still on the bus
        else
            next_pc = pc + addr_t'(control.pc_increment);
    end

    assign address =
        (control.addr_pc       ? pc                      : '0) |
        (control.addr_zeropage ? {8'h00, data_byte}      : '0) |
        (control.addr_absolute ? {data_byte, address_low} : '0);

    always_comb
    begin
        case (control.store_select)
            2'b00:   store_data = y;  // STY
            2'b10:   store_data = x;  // STX
            default: store_data = a;  // STA
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            pc    <= reset_vector_low;
            a     <= '0;
            x     <= '0;
            y     <= '0;
            flags <= '{i: 1'b1, default: 1'b0};  // Interrupts masked
        end
        else if (enable)
        begin
            pc <= next_pc;
            if (control.load_a) a <= db;
            if (control.load_x) x <= db;
            if (control.load_y) y <= db;

            if (control.n_db) flags.n <= db[7];
            if (control.z_db) flags.z <= db == 8'h00;
            if (control.v_alu)
                flags.v <= alu_overflow;
            else if (control.v_op)
                flags.v <= 1'b0;      // CLV only clears
            if (control.c_alu)
                flags.c <= alu_carry;
            else if (control.c_op)
                flags.c <= control.flag_value;
            if (control.i_op) flags.i <= control.flag_value;
            if (control.d_op) flags.d <= control.flag_value;  // Stored, no decimal mode
        end
    end

    always_ff @(posedge clock)
    begin
        if (enable)
        begin
            // After a write the core sees its own data
            data_byte   <= control.write_enable ? store_data : data_in;
            address_low <= data_byte;
            branch_sum  <= branch_result;
        end
    end

    assign alu_a = a;

    assign bus.address      = address;
    assign bus.data_out     = store_data;
    assign bus.write_enable = control.write_enable;

    assign debug.opcode = opcode;
    assign debug.pc     = pc;
    assign debug.a      = a;
    assign debug.x      = x;
    assign debug.y      = y;
    assign debug.status = {flags.n, flags.v, 2'b11, flags.d, flags.i, flags.z, flags.c};

endmodule

// ==== source/cpu_decode.sv ====
module cpu_decode
(
    input  cpu_pkg::byte_t   opcode,
    output cpu_pkg::decode_t decoded
);

    logic alu_column;   // Column xxx_xxx_x1
    logic load_store;   // Rows 80 and A0
    logic lda;
    logic ldx;
    logic ldy;
    logic immediate_a;
    logic immediate_xy;

    assign alu_column   = opcode ==? 8'b???_???_?1;
    assign load_store   = opcode ==? 8'b10?_???_??;
    assign lda          = opcode ==? 8'b101_???_?1;
    assign ldx          = opcode ==? 8'b101_0??_1?;  // LDX #,zp,abs and TAX
    assign ldy          = opcode ==? 8'b101_0??_00;  // Leaves out BCS and CLV
    assign immediate_a  = opcode ==? 8'b???_010_?1;
    assign immediate_xy = opcode ==? 8'b1??_000_?0;  // LDX/LDY #

    always_comb
    begin
        decoded.load         = opcode ==? 8'b101_0??_??;
        decoded.store        = opcode ==? 8'b100_???_??;
        decoded.arith        = alu_column & ~load_store;
        decoded.adc_sbc      = opcode ==? 8'b?11_???_?1;
        decoded.one_byte     = opcode ==? 8'b???_?10_?0;
        decoded.relative     = opcode ==? 8'b???_100_00;
        decoded.zeropage     = opcode ==? 8'b???_001_??;
        decoded.absolute     = opcode ==? 8'b???_011_??;  // Includes JMP
        decoded.jmp_absolute = opcode == 8'h4c;

        decoded.tax_tay = opcode ==? 8'b101_010_?0;
        decoded.txa     = opcode == 8'h8a;
        decoded.tya     = opcode == 8'h98;
        decoded.inx     = opcode == 8'he8;
        decoded.iny     = opcode == 8'hc8;
        decoded.dex     = opcode == 8'hca;
        decoded.dey     = opcode == 8'h88;

        // Flag ops, set or clear by bit 5
        decoded.clc_sec = opcode ==? 8'b00?_110_00;
        decoded.cli_sei = opcode ==? 8'b01?_110_00;
        decoded.cld_sed = opcode ==? 8'b11?_110_00;
        decoded.clv     = opcode == 8'hb8;

        decoded.two_cycle = immediate_a | immediate_xy | decoded.one_byte;

        decoded.update_a = lda | decoded.txa | decoded.tya | decoded.arith;
        decoded.update_x = ldx | decoded.inx | decoded.dex;
        decoded.update_y = ldy | decoded.iny | decoded.dey;
    end

endmodule

// ==== source/cpu_pkg.sv ====
package cpu_pkg;

    typedef logic [7:0]  byte_t;   // Data byte or register value
    typedef logic [15:0] addr_t;   // Bus address or PC value
    typedef logic [2:0]  alu_op_t; // Opcode bits 7:5

    // Bus cycle kinds
    typedef enum logic [2:0] {
        st_opcode,        // Opcode fetch, sync high
        st_operand,       // Second instruction byte
        st_address_high,  // Third instruction byte
        st_zeropage,      // Access at 00:operand
        st_absolute,      // Access at 16-bit operand
        st_branch_low,    // PCL := PCL + offset
        st_branch_high    // PCH fix-up after a page cross
    } cpu_state_t;

    // Instruction classes from the opcode
    typedef struct packed {
        logic load;          // LDA/LDX/LDY/TAX/TAY
        logic store;         // STA/STX/STY
        logic arith;         // ORA/AND/EOR/ADC/SBC
        logic adc_sbc;
        logic one_byte;      // Implied
        logic two_cycle;     // Implied or immediate
        logic relative;      // Conditional branch
        logic zeropage;
        logic absolute;
        logic jmp_absolute;
        logic tax_tay;
        logic txa;
        logic tya;
        logic inx;
        logic iny;
        logic dex;
        logic dey;
        logic clc_sec;
        logic cli_sei;
        logic cld_sed;
        logic clv;
        logic update_a;
        logic update_x;
        logic update_y;
    } decode_t;

    // Control word for one bus cycle
    typedef struct packed {
        logic    pc_increment;
        logic    pc_branch_low;   // PCL from branch sum
        logic    pc_branch_high;  // PCH from branch carry
        logic    pc_vector;       // PC from the last two bytes read
        logic    addr_pc;
        logic    addr_zeropage;
        logic    addr_absolute;
        logic    write_enable;
        logic [1:0] store_select; // Opcode bits 1:0
        logic    db_data_in;
        logic    db_alu;
        logic    db_a;
        logic    db_x;
        logic    db_y;
        logic    db_inc_x;
        logic    db_inc_y;
        logic    db_dec_x;
        logic    db_dec_y;
        alu_op_t alu_op;
        logic    n_db;            // N from DB bit 7
        logic    z_db;            // Z from DB == 0
        logic    v_alu;
        logic    c_alu;
        logic    c_op;            // CLC/SEC
        logic    i_op;            // CLI/SEI
        logic    d_op;            // CLD/SED
        logic    v_op;            // CLV
        logic    flag_value;      // Opcode bit 5
        logic    load_a;
        logic    load_x;
        logic    load_y;
    } control_t;

    typedef struct packed {
        logic n;
        logic v;
        logic d;
        logic i;
        logic z;
        logic c;
    } flags_t;

    // Memory side
    typedef struct packed {
        addr_t address;
        byte_t data_out;
        logic  write_enable;
    } bus_t;

    typedef struct packed {
        byte_t opcode;
        addr_t pc;
        byte_t a;
        byte_t x;
        byte_t y;
        byte_t status;
    } debug_t;

    localparam addr_t reset_vector_low = 16'hfffc;
    localparam byte_t reset_opcode     = 8'h4c;  // JMP absolute through the vector

endpackage

// ==== source/cpu_sequencer.sv ====
module cpu_sequencer
(
    input  logic              clock,
    input  logic              reset,
    input  logic              enable,
    input  cpu_pkg::byte_t    data_in,
    input  cpu_pkg::decode_t  decoded,
    input  cpu_pkg::flags_t   flags,
    input  logic              branch_cross,
    output cpu_pkg::byte_t    opcode,
    output cpu_pkg::control_t control,
    output logic              sync
);

    import cpu_pkg::*;

    cpu_state_t state;
    cpu_state_t next_state;
    logic [3:0] branch_flags;
    logic       branch_taken;

    // 00 BPL/BMI, 01 BVC/BVS, 10 BCC/BCS, 11 BNE/BEQ
    assign branch_flags = {flags.z, flags.c, flags.v, flags.n};
    assign branch_taken = branch_flags[opcode[7:6]] == opcode[5];

    always_comb
    begin
        control    = '0;
        next_state = st_opcode;

        control.alu_op       = opcode[7:5];
        control.store_select = opcode[1:0];  // 00 Y, 01 A, 10 X
        control.flag_value   = opcode[5];

        case (state)
            st_opcode:
            begin
                next_state           = st_operand;
                control.addr_pc      = 1'b1;
                control.pc_increment = 1'b1;

                // Results of the previous instruction land here
                control.db_data_in = decoded.load & ~decoded.one_byte;
                control.db_alu     = decoded.arith;
                control.db_a       = decoded.tax_tay;
                control.db_x       = decoded.txa;
                control.db_y       = decoded.tya;
                control.db_inc_x   = decoded.inx;
                control.db_inc_y   = decoded.iny;
                control.db_dec_x   = decoded.dex;
                control.db_dec_y   = decoded.dey;

                control.c_op  = decoded.clc_sec;
                control.i_op  = decoded.cli_sei;
                control.d_op  = decoded.cld_sed;
                control.v_op  = decoded.clv;
                control.v_alu = decoded.adc_sbc;
                control.c_alu = decoded.adc_sbc;

                control.n_db = decoded.update_a | decoded.update_x | decoded.update_y;
                control.z_db = control.n_db;

                control.load_a = decoded.update_a;
                control.load_x = decoded.update_x;
                control.load_y = decoded.update_y;
            end

            st_operand:
            begin
                // Opcode is now in the instruction register
                control.addr_pc      = 1'b1;
                control.pc_increment = ~decoded.one_byte;  // Implied ops reread this byte
                if (!decoded.two_cycle)
                begin
                    if (decoded.zeropage)
                        next_state = st_zeropage;
                    else if (decoded.absolute)
                        next_state = st_address_high;
                    else if (decoded.relative && branch_taken)
                        next_state = st_branch_low;
                end
            end

            st_address_high:
            begin
                control.addr_pc      = 1'b1;
                control.pc_increment = 1'b1;
                if (decoded.jmp_absolute)
                    control.pc_vector = 1'b1;  // Also the reset path
                else
                    next_state = st_absolute;
            end

            st_zeropage:
            begin
                control.addr_zeropage = 1'b1;
                control.write_enable  = decoded.store;  // STx writes in its last cycle
            end

            st_absolute:
            begin
                control.addr_absolute = 1'b1;
                control.write_enable  = decoded.store;
            end

            st_branch_low:
            begin
                control.addr_pc       = 1'b1;  // Dummy read
                control.pc_branch_low = 1'b1;
                if (branch_cross)
                    next_state = st_branch_high;
            end

            st_branch_high:
            begin
                control.addr_pc        = 1'b1;
                control.pc_branch_high = 1'b1;
            end

            default:
            begin
                next_state = st_opcode;
            end
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state  <= st_operand;    // Pretend JMP, read the vector
            opcode <= reset_opcode;
        end
        else if (enable)
        begin
            state <= next_state;
            if (state == st_opcode)
                opcode <= data_in;   // Instruction register
        end
    end

    assign sync = state == st_opcode;

endmodule

// ==== source/cpu_top.sv ====
module cpu_top
(
    input  logic            clock,
    input  logic            reset,
    input  logic            enable,
    input  cpu_pkg::byte_t  data_in,
    output cpu_pkg::bus_t   bus,
    output logic            sync,
    output cpu_pkg::debug_t debug
);

    import cpu_pkg::*;

    byte_t    opcode;        // Instruction register
    control_t control;
    decode_t  decoded;
    flags_t   flags;
    logic     branch_cross;
    byte_t    alu_a;
    byte_t    data_byte;     // Registered data_in
    byte_t    alu_result;
    logic     alu_carry;
    logic     alu_overflow;

    cpu_sequencer i_sequencer
    (
        .clock        (clock),
        .reset        (reset),
        .enable       (enable),
        .data_in      (data_in),
        .decoded      (decoded),
        .flags        (flags),
        .branch_cross (branch_cross),
        .opcode       (opcode),
        .control      (control),
        .sync         (sync)
    );

    cpu_decode i_decode
    (
        .opcode  (opcode),
        .decoded (decoded)
    );

    cpu_alu i_alu
    (
        .a         (alu_a),
        .b         (data_byte),
        .carry_in  (flags.c),
        .op        (control.alu_op),
        .result    (alu_result),
        .carry_out (alu_carry),
        .overflow  (alu_overflow)
    );

    cpu_datapath i_datapath
    (
        .clock        (clock),
        .reset        (reset),
        .enable       (enable),
        .data_in      (data_in),
        .control      (control),
        .opcode       (opcode),
        .alu_result   (alu_result),
        .alu_carry    (alu_carry),
        .alu_overflow (alu_overflow),
        .alu_a        (alu_a),
        .data_byte    (data_byte),
        .flags        (flags),
        .branch_cross (branch_cross),
        .bus          (bus),
        .debug        (debug)
    );

endmodule

// ==== tests/cpu_props.sv ====
module cpu_props
(
    input logic           clock,
    input logic           reset,
    input logic           sync,
    input cpu_pkg::bus_t  bus
);

    timeunit 1ns;
    timeprecision 1ps;

    import cpu_pkg::*;

    // Opcode fetch is always a read
    no_write_in_fetch: assert property (
        @(posedge clock) disable iff (reset) !(sync && bus.write_enable))
        else $error("write_enable and sync high in the same cycle");

    // Core restarts with the vector read, not a fetch
    sync_low_after_reset: assert property (
        @(posedge clock) $fell(reset) |-> !sync)
        else $error("sync high in the first cycle after reset");

    vector_address: assert property (
        @(posedge clock) $fell(reset) |-> bus.address == reset_vector_low)
        else $error("first address after reset is not the reset vector");

endmodule

bind cpu_top cpu_props i_props
(
    .clock (clock),
    .reset (reset),
    .sync  (sync),
    .bus   (bus)
);

// ==== tests/cpu_tb.sv ====
module cpu_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import cpu_pkg::*;

    localparam int    clock_period = 8;
    localparam int    mem_size     = 65536;
    localparam int    step_count   = 800;    // Instructions checked
    localparam int    sync_timeout = 64;     // Enabled cycles allowed between fetches
    localparam int    run_timeout  = 40000;  // Clock cycles for the whole run
    localparam addr_t code_base    = 16'h0400;

    // Model of the programmer-visible state after one instruction
    typedef struct packed {
        addr_t      pc;
        byte_t      a;
        byte_t      x;
        byte_t      y;
        flags_t     f;
        logic [2:0] cycles;      // Enabled cycles of the instruction just run
        logic       store;
        addr_t      store_addr;
        byte_t      store_data;
    } model_t;

    logic   clock = 1'b0;
    logic   reset;
    logic   enable;
    byte_t  data_in;
    bus_t   bus;
    logic   sync;
    debug_t debug;

    byte_t  mem       [mem_size];  // Memory seen by the DUT
    byte_t  model_mem [mem_size];  // Memory of the reference model
    integer seed = 32'h170ee6f6;
    addr_t  gen_addr;              // Program generation pointer
    model_t model;
    model_t prev;                  // State one instruction behind as seen on debug
    byte_t  last_opcode;           // Opcode expected in the instruction register
    int     errors = 0;
    int     checks = 0;
    int     steps = 0;
    int     cycle_count = 0;       // Enabled cycles since the last fetch
    int     expected_cycles = 2;   // Reset sequence reads FFFC and FFFD
    int     idle = 0;
    int     writes = 0;            // Write cycles since the last fetch

    byte_t implied_ops [15] = '{8'haa, 8'ha8, 8'h8a, 8'h98, 8'he8, 8'hca, 8'hc8, 8'h88,
                                8'h18, 8'h38, 8'h58, 8'h78, 8'hd8, 8'hf8, 8'hb8};
    byte_t immediate_ops [8] = '{8'ha9, 8'ha2, 8'ha0, 8'h09, 8'h29, 8'h49, 8'h69, 8'he9};
    byte_t zeropage_ops [11] = '{8'ha5, 8'ha6, 8'ha4, 8'h05, 8'h25, 8'h45, 8'h65, 8'he5,
                                 8'h85, 8'h86, 8'h84};
    byte_t absolute_ops [11] = '{8'had, 8'hae, 8'hac, 8'h0d, 8'h2d, 8'h4d, 8'h6d, 8'hed,
                                 8'h8d, 8'h8e, 8'h8c};
    byte_t branch_ops [8] = '{8'h10, 8'h30, 8'h50, 8'h70, 8'h90, 8'hb0, 8'hd0, 8'hf0};

    cpu_top i_dut
    (
        .clock   (clock),
        .reset   (reset),
        .enable  (enable),
        .data_in (data_in),
        .bus     (bus),
        .sync    (sync),
        .debug   (debug)
    );

    initial
    begin
        forever #(clock_period / 2) clock = ~clock;
    end

    function automatic int rnd(input int range);
        return int'($unsigned($random(seed)) % range);
    endfunction

    function automatic byte_t status_byte(input flags_t f);
        return {f.n, f.v, 2'b11, f.d, f.i, f.z, f.c};  // Bits 5 and 4 read as one
    endfunction

    task automatic put_byte(input byte_t value);
        mem[gen_addr] = value;
        gen_addr = gen_addr + 16'd1;
    endtask

    // Forward branch over one-byte fillers keeps both paths on instruction starts
    task automatic place_branch();
        int skip;
        skip = rnd(12);
        put_byte(branch_ops[rnd(8)]);
        put_byte(byte_t'(skip));
        repeat (skip) put_byte(implied_ops[rnd(15)]);
    endtask

    task automatic random_instruction();
        case (rnd(5))
            0: put_byte(implied_ops[rnd(15)]);
            1:
            begin
                put_byte(immediate_ops[rnd(8)]);
                put_byte(byte_t'(rnd(256)));
            end
            2:
            begin
                put_byte(zeropage_ops[rnd(11)]);
                put_byte(byte_t'(rnd(256)));
            end
            3:
            begin
                put_byte(absolute_ops[rnd(11)]);
                put_byte(byte_t'(rnd(256)));
                put_byte(8'h02 + byte_t'(rnd(2)));  // Data area 0200..03FF
            end
            default: place_branch();
        endcase
    endtask

    task automatic generate_program();
        addr_t start;
        addr_t landing;
        for (int i = 0; i < mem_size; i++)
            mem[i] = byte_t'(i) ^ byte_t'(i >> 8) ^ 8'h5a;  // Depends on both address bytes
        start = code_base + addr_t'(rnd(64));
        mem[16'hfffc] = start[7:0];
        mem[16'hfffd] = start[15:8];
        gen_addr = start;
        for (int segment = 0; segment < 10; segment++)
        begin
            repeat (60) random_instruction();
            // Jump near the end of the next page so branches there cross it
            landing = {gen_addr[15:8] + 8'd1, 8'hf0 + byte_t'(rnd(12))};
            put_byte(8'h4c);
            put_byte(landing[7:0]);
            put_byte(landing[15:8]);
            gen_addr = landing;
            place_branch();
        end
        landing = gen_addr;
        put_byte(8'h4c);             // Park in a loop at the end
        put_byte(landing[7:0]);
        put_byte(landing[15:8]);
        for (int i = 0; i < mem_size; i++)
            model_mem[i] = mem[i];
    endtask

    // Reference model of one instruction by the 6502 rules
    function automatic model_t execute(input model_t s);
        model_t     n;
        byte_t      op;
        byte_t      b1;
        byte_t      b2;
        byte_t      m;
        byte_t      r;
        addr_t      ea;
        addr_t      next;
        addr_t      target;
        logic [8:0] sum;
        logic       nz;
        logic       cond;
        n = s;
        op = model_mem[s.pc];
        b1 = model_mem[s.pc + 16'd1];
        b2 = model_mem[s.pc + 16'd2];
        n.store = 1'b0;
        n.cycles = 3'd2;
        n.pc = s.pc + 16'd2;
        ea = 16'h0000;
        m = b1;                      // Immediate operand
        r = 8'h00;
        nz = 1'b1;
        cond = 1'b0;

        // Addressing mode
        case (op)
            8'haa, 8'ha8, 8'h8a, 8'h98, 8'he8, 8'hca, 8'hc8, 8'h88,
            8'h18, 8'h38, 8'h58, 8'h78, 8'hd8, 8'hf8, 8'hb8:
                n.pc = s.pc + 16'd1;
            8'ha5, 8'ha6, 8'ha4, 8'h05, 8'h25, 8'h45, 8'h65, 8'he5, 8'h85, 8'h86, 8'h84:
            begin
                ea = {8'h00, b1};
                m = model_mem[ea];
                n.cycles = 3'd3;
            end
            8'had, 8'hae, 8'hac, 8'h0d, 8'h2d, 8'h4d, 8'h6d, 8'hed, 8'h8d, 8'h8e, 8'h8c:
            begin
                ea = {b2, b1};
                m = model_mem[ea];
                n.cycles = 3'd4;
                n.pc = s.pc + 16'd3;
            end
            default: ;
        endcase

        case (op)
            8'ha9, 8'ha5, 8'had, 8'ha2, 8'ha6, 8'hae, 8'ha0, 8'ha4, 8'hac:
                r = m;
            8'h09, 8'h05, 8'h0d: r = s.a | m;
            8'h29, 8'h25, 8'h2d: r = s.a & m;
            8'h49, 8'h45, 8'h4d: r = s.a ^ m;
            8'h69, 8'h65, 8'h6d, 8'he9, 8'he5, 8'hed:
            begin
                if (op inside {8'he9, 8'he5, 8'hed})
                    m = ~m;          // Subtract as A + ~M + C
                sum = {1'b0, s.a} + {1'b0, m} + {8'h00, s.f.c};
                r = sum[7:0];
                n.f.c = sum[8];
                n.f.v = (s.a[7] == m[7]) && (r[7] != s.a[7]);
            end
            8'h85, 8'h8d, 8'h86, 8'h8e, 8'h84, 8'h8c:
            begin
                n.store = 1'b1;
                n.store_addr = ea;
                case (op)
                    8'h85, 8'h8d: n.store_data = s.a;  // STA
                    8'h86, 8'h8e: n.store_data = s.x;  // STX
                    default:      n.store_data = s.y;  // STY
                endcase
                model_mem[ea] = n.store_data;
            end
            8'haa, 8'ha8: r = s.a;
            8'h8a: r = s.x;
            8'h98: r = s.y;
            8'he8: r = s.x + 8'd1;
            8'hca: r = s.x - 8'd1;
            8'hc8: r = s.y + 8'd1;
            8'h88: r = s.y - 8'd1;
            8'h18: n.f.c = 1'b0;
            8'h38: n.f.c = 1'b1;
            8'h58: n.f.i = 1'b0;
            8'h78: n.f.i = 1'b1;
            8'hd8: n.f.d = 1'b0;
            8'hf8: n.f.d = 1'b1;
            8'hb8: n.f.v = 1'b0;
            8'h4c:
            begin
                n.pc = {b2, b1};
                n.cycles = 3'd3;
            end
            default:
            begin
                case (op)
                    8'h10: cond = !s.f.n;
                    8'h30: cond = s.f.n;
                    8'h50: cond = !s.f.v;
                    8'h70: cond = s.f.v;
                    8'h90: cond = !s.f.c;
                    8'hb0: cond = s.f.c;
                    8'hd0: cond = !s.f.z;
                    default: cond = s.f.z;   // BEQ
                endcase
                next = s.pc + 16'd2;
                target = next + {{8{b1[7]}}, b1};
                if (cond)
                begin
                    n.pc = target;
                    n.cycles = (target[15:8] != next[15:8]) ? 3'd4 : 3'd3;
                end
            end
        endcase

        // Register that takes r, and with it N and Z
        case (op)
            8'ha9, 8'ha5, 8'had, 8'h09, 8'h05, 8'h0d, 8'h29, 8'h25, 8'h2d,
            8'h49, 8'h45, 8'h4d, 8'h69, 8'h65, 8'h6d, 8'he9, 8'he5, 8'hed,
            8'h8a, 8'h98:
                n.a = r;
            8'ha2, 8'ha6, 8'hae, 8'haa, 8'he8, 8'hca:
                n.x = r;
            8'ha0, 8'ha4, 8'hac, 8'ha8, 8'hc8, 8'h88:
                n.y = r;
            default:
                nz = 1'b0;
        endcase

        if (nz)
        begin
            n.f.n = r[7];
            n.f.z = r == 8'h00;
        end
        return n;
    endfunction

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] expected);
        checks++;
        if (got !== expected)
        begin
            errors++;
            $display("MISMATCH %s: expected %h, got %h (instruction %0d)",
                     name, expected, got, steps);
        end
    endtask

    // Inputs change on the falling edge
    always @(negedge clock)
    begin
        logic go;
        go = rnd(4) != 0;            // About one cycle in four frozen
        if (go && bus.write_enable)
            mem[bus.address] = bus.data_out;
        enable = go;
        data_in = mem[bus.address];
    end

    // Outputs are sampled before the rising edge updates them
    always @(posedge clock)
    begin
        if (!reset && enable)
        begin
            if (bus.write_enable)
            begin
                writes++;
                if (!model.store)
                begin
                    errors++;
                    $display("Write to address %h by an instruction that does not store",
                             bus.address);
                end
                else
                begin
                    check_value("bus.address", bus.address, model.store_addr);
                    check_value("bus.data_out", 16'(bus.data_out), 16'(model.store_data));
                end
            end

            if (sync)
            begin
                check_value("cycles", 16'(cycle_count), 16'(expected_cycles));
                check_value("bus.write_enable cycles", 16'(writes), 16'(model.store));
                check_value("debug.pc", debug.pc, model.pc);
                check_value("bus.address", bus.address, model.pc);
                check_value("debug.opcode", 16'(debug.opcode), 16'(last_opcode));
                check_value("debug.a", 16'(debug.a), 16'(prev.a));
                check_value("debug.x", 16'(debug.x), 16'(prev.x));
                check_value("debug.y", 16'(debug.y), 16'(prev.y));
                check_value("debug.status", 16'(debug.status), 16'(status_byte(prev.f)));
                if (model.store)
                    check_value("memory", 16'(mem[model.store_addr]), 16'(model.store_data));
                prev = model;
                last_opcode = model_mem[model.pc];
                model = execute(model);
                expected_cycles = int'(model.cycles);
                steps++;
                cycle_count = 1;
                idle = 0;
                writes = 0;
            end
            else
            begin
                cycle_count++;
                idle++;
                if (idle > sync_timeout)
                begin
                    errors++;
                    $display("No opcode fetch within %0d enabled cycles at address %h",
                             sync_timeout, bus.address);
                    idle = 0;
                end
            end
        end
    end

    initial
    begin
        int waited;
        reset = 1'b1;
        enable = 1'b0;
        data_in = 8'h00;
        generate_program();
        model = '0;
        model.pc = {mem[16'hfffd], mem[16'hfffc]};
        model.f.i = 1'b1;            // Interrupts masked out of reset
        prev = model;
        last_opcode = reset_opcode;  // Reset leaves JMP in the instruction register

        repeat (4) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        waited = 0;
        while (steps < step_count && waited < run_timeout)
        begin
            @(negedge clock);
            waited++;
        end
        if (steps < step_count)
        begin
            errors++;
            $display("Timeout after %0d cycles with %0d of %0d instructions done",
                     waited, steps, step_count);
        end

        $display("Summary: %0d instructions, %0d checks, %0d errors", steps, checks, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule
